//--- Makefile
.PHONY: all lint clean

all: obj_dir/Vmd_unit_tb
	@out=$$(./obj_dir/Vmd_unit_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

obj_dir/Vmd_unit_tb: files.f design/*.sv tests/*.sv
	verilator --binary --assert --top-module md_unit_tb -f files.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module md_unit_tb -f files.f

clean:
	rm -rf obj_dir

//--- design/booth_mul.sv
module booth_mul import md_pkg::*; #(
   parameter int mul_digits_per_cycle = MUL_DIGITS_PER_CYCLE_DEF
) (
   input  logic      clk,
   input  logic      load,
   input  logic      step,
   input  md_req_t   req,
   output md_dword_t product
);

   logic [35:0] mplier;       // consumed from the bottom
   logic        mplier_prev;  // bit below lowest digit
   logic [36:0] mplier_ext;
   logic [32:0] mcand;
   logic [4:0]  base;         // digit index of mplier[1:0]
   md_dword_t   acc;
   md_dword_t   acc_next;
   logic [2:0]  digit [mul_digits_per_cycle];
   logic [34:0] pp    [mul_digits_per_cycle];

   assign mplier_ext = {mplier, mplier_prev};

   for (genvar k = 0; k < mul_digits_per_cycle; k++) begin : g_pp
      assign digit[k] = mplier_ext[2*k+2 -: 3];  // overlapping triplet

      booth_pp u_pp (
         .digit        (digit[k]),
         .multiplicand (mcand),
         .pp           (pp[k])
      );
   end

   always_comb begin
      acc_next = acc;
      for (int k = 0; k < mul_digits_per_cycle; k++) begin
         acc_next = acc_next + ({{29{pp[k][34]}}, pp[k]} << (2 * (int'(base) + k)));
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         mplier      <= {{4{req.in_1_signed & req.in_1[31]}}, req.in_1};
         mplier_prev <= 1'b0;
         mcand       <= {req.in_2_signed & req.in_2[31], req.in_2};
         acc         <= '0;
         base        <= '0;
      end else if (step) begin
         acc         <= acc_next;
         mplier_prev <= mplier[2*mul_digits_per_cycle-1];
         mplier      <= 36'($signed(mplier) >>> (2 * mul_digits_per_cycle));
         base        <= base + 5'(mul_digits_per_cycle);
      end
   end

   // the last step's sum is visible in its own cycle
   assign product = step ? acc_next : acc;

endmodule

//--- design/booth_pp.sv
module booth_pp (
   input  logic [2:0]  digit,
   input  logic [32:0] multiplicand,
   output logic [34:0] pp
);

   logic [34:0] m_ext;

   assign m_ext = {{2{multiplicand[32]}}, multiplicand};  // room for x2 and negate

   // radix-4 recoding of {b[2k+1], b[2k], b[2k-1]}
   always_comb begin
      case (digit)
         3'b001, 3'b010: begin
            pp = m_ext;  // +1
         end
         3'b011: begin
            pp = m_ext << 1;  // +2
         end
         3'b100: begin
            pp = -(m_ext << 1);  // -2
         end
         3'b101, 3'b110: begin
            pp = -m_ext;  // -1
         end
         default: begin
            pp = '0;  // 000 and 111
         end
      endcase
   end

endmodule

//--- design/div_iter.sv
module div_iter import md_pkg::*; (
   input  logic     clk,
   input  logic     load,
   input  logic     step,
   input  md_req_t  req,
   output md_word_t quotient,
   output md_word_t remainder
);

   logic [63:0] rq;       // {partial remainder, dividend / quotient bits}
   logic [63:0] rq_next;
   md_word_t    dvs;      // divisor magnitude
   logic        dvd_neg;
   logic        dvs_neg;

   // one restoring round: shift, trial subtract, keep if non-negative
   function automatic logic [63:0] div_round(logic [63:0] cur, md_word_t d);
      logic [32:0] trial;
      trial = cur[63:31] - {1'b0, d};
      if (!trial[32]) begin
         return {trial[31:0], cur[30:0], 1'b1};
      end
      return {cur[62:0], 1'b0};
   endfunction

   assign dvd_neg = req.in_1_signed & req.in_1[31];
   assign dvs_neg = req.in_2_signed & req.in_2[31];

   assign rq_next = div_round(div_round(rq, dvs), dvs);  // two bits per step

   always_ff @(posedge clk) begin
      if (load) begin
         rq[63:32] <= '0;
         if (dvd_neg) begin
            rq[31:0] <= -req.in_1;
         end else begin
            rq[31:0] <= req.in_1;
         end
         if (dvs_neg) begin
            dvs <= -req.in_2;
         end else begin
            dvs <= req.in_2;
         end
      end else if (step) begin
         rq <= rq_next;
      end
   end

   // zero divisor: every trial passes, so q is all ones and rem the dividend
   assign quotient  = step ? rq_next[31:0]  : rq[31:0];
   assign remainder = step ? rq_next[63:32] : rq[63:32];

endmodule

//--- design/md_ctrl.sv
module md_ctrl import md_pkg::*; #(
   parameter int mul_digits_per_cycle = MUL_DIGITS_PER_CYCLE_DEF
) (
   input  logic    clk,
   input  logic    reset,
   input  logic    req_valid,
   input  md_req_t req,
   output logic    req_ready,
   output logic    resp_valid,
   output logic    load,
   output logic    step,
   output logic    finish,
   output md_req_t cur_req
);

   localparam int mul_steps = MUL_DIGITS / mul_digits_per_cycle;

   logic                busy;
   logic [MD_CNT_W-1:0] cnt;  // iterations left, incl. current

   assign req_ready = ~busy;
   assign load      = req_valid & req_ready;  // accept strobe
   assign step      = busy;
   assign finish    = busy & (cnt == MD_CNT_W'(1));

   always_ff @(posedge clk) begin
      if (reset) begin
         busy       <= 1'b0;
         cnt        <= '0;
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= finish;  // result reg loads on the same edge
         if (load) begin
            busy <= 1'b1;
            if (req.op == MD_OP_DIV) begin
               cnt <= MD_CNT_W'(DIV_STEPS);
            end else begin
               cnt <= MD_CNT_W'(mul_steps);
            end
         end else if (step) begin
            cnt <= cnt - MD_CNT_W'(1);
            if (finish) begin
               busy <= 1'b0;  // ready again with resp_valid
            end
         end
      end
   end

   // request held for the fix-up and select stage
   always_ff @(posedge clk) begin
      if (load) begin
         cur_req <= req;
      end
   end

endmodule

//--- design/md_pkg.sv
package md_pkg;

   // data words
   typedef logic [31:0] md_word_t;
   typedef logic [63:0] md_dword_t;  // full product

   typedef enum logic {
      MD_OP_MUL = 1'b0,
      MD_OP_DIV = 1'b1
   } md_op_e;

   // mul: hi/lo half of product; div: remainder/quotient
   typedef enum logic {
      MD_OUT_LO = 1'b0,
      MD_OUT_HI = 1'b1
   } md_sel_e;

   typedef struct packed {
      md_op_e   op;
      md_sel_e  out_sel;
      logic     in_1_signed;
      logic     in_2_signed;
      md_word_t in_1;  // multiplier / dividend
      md_word_t in_2;  // multiplicand / divisor
   } md_req_t;

   // radix-4 digits over the 36-bit extended multiplier
   localparam int MUL_DIGITS = 18;

   // two quotient bits per iteration
   localparam int DIV_STEPS = 16;

   localparam int MUL_DIGITS_PER_CYCLE_DEF = 6;

   // wide enough for the longest op
   localparam int MD_CNT_W = 5;

endpackage

//--- design/md_result.sv
module md_result import md_pkg::*; (
   input  logic      clk,
   input  logic      finish,
   input  md_req_t   cur_req,
   input  md_dword_t product,
   input  md_word_t  quotient,
   input  md_word_t  remainder,
   output md_word_t  resp_result
);

   logic     dvd_neg;
   logic     dvs_neg;
   md_word_t q_fix;
   md_word_t r_fix;
   md_word_t sel;

   assign dvd_neg = cur_req.in_1_signed & cur_req.in_1[31];
   assign dvs_neg = cur_req.in_2_signed & cur_req.in_2[31];

   always_comb begin
      q_fix = (dvd_neg ^ dvs_neg) ? -quotient : quotient;
      r_fix = dvd_neg ? -remainder : remainder;  // remainder follows dividend
      if (cur_req.in_2 == '0) begin
         q_fix = '1;
         r_fix = cur_req.in_1;
      end
      if (cur_req.op == MD_OP_MUL) begin
         sel = (cur_req.out_sel == MD_OUT_HI) ? product[63:32] : product[31:0];
      end else begin
         sel = (cur_req.out_sel == MD_OUT_HI) ? r_fix : q_fix;
      end
   end

   always_ff @(posedge clk) begin
      if (finish) begin
         resp_result <= sel;  // held until next completion
      end
   end

endmodule

//--- design/md_unit.sv
module md_unit import md_pkg::*; #(
   parameter int mul_digits_per_cycle = MUL_DIGITS_PER_CYCLE_DEF
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     req_valid,
   input  md_req_t  req,
   output logic     req_ready,
   output logic     resp_valid,
   output md_word_t resp_result
);

   logic      load;
   logic      step;
   logic      finish;
   md_req_t   cur_req;
   md_dword_t product;
   md_word_t  quotient;
   md_word_t  remainder;

   md_ctrl #(.mul_digits_per_cycle(mul_digits_per_cycle)) u_ctrl (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .load       (load),
      .step       (step),
      .finish     (finish),
      .cur_req    (cur_req)
   );

   booth_mul #(.mul_digits_per_cycle(mul_digits_per_cycle)) u_mul (
      .clk     (clk),
      .load    (load),
      .step    (step),
      .req     (req),
      .product (product)
   );

   div_iter u_div (
      .clk       (clk),
      .load      (load),
      .step      (step),
      .req       (req),
      .quotient  (quotient),
      .remainder (remainder)
   );

   md_result u_result (
      .clk         (clk),
      .finish      (finish),
      .cur_req     (cur_req),
      .product     (product),
      .quotient    (quotient),
      .remainder   (remainder),
      .resp_result (resp_result)
   );

endmodule

//--- files.f
design/md_pkg.sv
design/booth_pp.sv
design/booth_mul.sv
design/div_iter.sv
design/md_ctrl.sv
design/md_result.sv
design/md_unit.sv
tests/md_unit_props.sv
tests/md_unit_tb.sv

//--- tests/md_unit_props.sv
module md_unit_props (
   input logic clk,
   input logic reset,
   input logic req_ready,
   input logic resp_valid
);

   // response is a single-cycle pulse
   a_valid_pulse : assert property (
      @(posedge clk) disable iff (reset) resp_valid |=> !resp_valid
   ) else $error("resp_valid high for two cycles");

   a_ready_with_valid : assert property (
      @(posedge clk) disable iff (reset) resp_valid |-> req_ready
   ) else $error("req_ready low while resp_valid high");

   // idle state right after reset
   a_reset_state : assert property (
      @(posedge clk) $past(reset) |-> (req_ready && !resp_valid)
   ) else $error("wrong handshake state after reset");

endmodule

bind md_unit md_unit_props u_props (
   .clk        (clk),
   .reset      (reset),
   .req_ready  (req_ready),
   .resp_valid (resp_valid)
);

//--- tests/md_unit_tb.sv
module md_unit_tb import md_pkg::*;;

   localparam int MUL_LAT = 4;   // accept cycle to resp_valid cycle, 18 digits at 6 per step
   localparam int DIV_LAT = 17;
   localparam int TIMEOUT = 50;  // cycles
   localparam int NTBL    = 25;

   typedef struct packed {
      md_req_t  req;
      md_word_t exp;
   } vec_t;

   logic     clk;
   logic     reset;
   logic     req_valid;
   md_req_t  req;
   logic     req_ready;
   logic     resp_valid;
   md_word_t resp_result;
   int       ntest;
   int       errors;

   // op, out_sel, in_1_signed, in_2_signed, in_1, in_2, expected result
   vec_t tbl [NTBL] = '{
      '{'{MD_OP_MUL, MD_OUT_LO, 1'b0, 1'b0, 32'h00000007, 32'h00000006}, 32'h0000002a},
      '{'{MD_OP_MUL, MD_OUT_HI, 1'b0, 1'b0, 32'hffffffff, 32'hffffffff}, 32'hfffffffe},
      '{'{MD_OP_MUL, MD_OUT_LO, 1'b0, 1'b0, 32'hffffffff, 32'hffffffff}, 32'h00000001},
      '{'{MD_OP_MUL, MD_OUT_HI, 1'b1, 1'b1, 32'hffffffff, 32'hffffffff}, 32'h00000000},
      '{'{MD_OP_MUL, MD_OUT_HI, 1'b1, 1'b0, 32'hffffffff, 32'hffffffff}, 32'hffffffff},
      '{'{MD_OP_MUL, MD_OUT_HI, 1'b0, 1'b1, 32'hffffffff, 32'hffffffff}, 32'hffffffff},
      '{'{MD_OP_MUL, MD_OUT_HI, 1'b1, 1'b1, 32'h80000000, 32'h80000000}, 32'h40000000},
      '{'{MD_OP_MUL, MD_OUT_LO, 1'b1, 1'b1, 32'h80000000, 32'h80000000}, 32'h00000000},
      '{'{MD_OP_MUL, MD_OUT_HI, 1'b1, 1'b1, 32'h80000000, 32'hffffffff}, 32'h00000000},
      '{'{MD_OP_MUL, MD_OUT_LO, 1'b1, 1'b1, 32'h80000000, 32'hffffffff}, 32'h80000000},
      '{'{MD_OP_MUL, MD_OUT_HI, 1'b0, 1'b0, 32'h80000000, 32'hffffffff}, 32'h7fffffff},
      '{'{MD_OP_MUL, MD_OUT_LO, 1'b1, 1'b1, 32'hfffffffd, 32'h00000005}, 32'hfffffff1},
      '{'{MD_OP_DIV, MD_OUT_LO, 1'b0, 1'b0, 32'h00000064, 32'h00000007}, 32'h0000000e},
      '{'{MD_OP_DIV, MD_OUT_HI, 1'b0, 1'b0, 32'h00000064, 32'h00000007}, 32'h00000002},
      '{'{MD_OP_DIV, MD_OUT_LO, 1'b1, 1'b1, 32'hffffff9c, 32'h00000007}, 32'hfffffff2},
      '{'{MD_OP_DIV, MD_OUT_HI, 1'b1, 1'b1, 32'hffffff9c, 32'h00000007}, 32'hfffffffe},
      '{'{MD_OP_DIV, MD_OUT_LO, 1'b1, 1'b1, 32'h00000064, 32'hfffffff9}, 32'hfffffff2},
      '{'{MD_OP_DIV, MD_OUT_HI, 1'b1, 1'b1, 32'h00000064, 32'hfffffff9}, 32'h00000002},
      '{'{MD_OP_DIV, MD_OUT_HI, 1'b1, 1'b1, 32'hffffff9c, 32'hfffffff9}, 32'hfffffffe},
      '{'{MD_OP_DIV, MD_OUT_LO, 1'b0, 1'b0, 32'hffffff9c, 32'h00000007}, 32'h24924916},
      '{'{MD_OP_DIV, MD_OUT_LO, 1'b0, 1'b0, 32'h000004d2, 32'h00000000}, 32'hffffffff},
      '{'{MD_OP_DIV, MD_OUT_HI, 1'b0, 1'b0, 32'h000004d2, 32'h00000000}, 32'h000004d2},
      '{'{MD_OP_DIV, MD_OUT_HI, 1'b1, 1'b1, 32'hfffffffb, 32'h00000000}, 32'hfffffffb},
      '{'{MD_OP_DIV, MD_OUT_LO, 1'b1, 1'b1, 32'h80000000, 32'hffffffff}, 32'h80000000},
      '{'{MD_OP_DIV, MD_OUT_HI, 1'b1, 1'b1, 32'h80000000, 32'hffffffff}, 32'h00000000}
   };

   md_unit UUT (
      .clk         (clk),
      .reset       (reset),
      .req_valid   (req_valid),
      .req         (req),
      .req_ready   (req_ready),
      .resp_valid  (resp_valid),
      .resp_result (resp_result)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // 64-bit integer model of the mul/div rules
   function automatic md_word_t model_result(md_req_t r);
      longint a;
      longint b;
      longint p;
      logic   hi;
      a  = r.in_1_signed ? longint'($signed(r.in_1)) : longint'({32'b0, r.in_1});
      b  = r.in_2_signed ? longint'($signed(r.in_2)) : longint'({32'b0, r.in_2});
      hi = (r.out_sel == MD_OUT_HI);
      if (r.op == MD_OP_MUL) begin
         p = a * b;
         return hi ? p[63:32] : p[31:0];
      end
      if (r.in_2 == '0) begin
         return hi ? r.in_1 : '1;  // divide by zero
      end
      return hi ? md_word_t'(a % b) : md_word_t'(a / b);
   endfunction

   task automatic check_result(input md_word_t got, input md_word_t exp);
      if (got !== exp) begin
         $display("** Error: resp_result = 0x%h, expected 0x%h", got, exp);
         errors++;
      end
   endtask

   task automatic check_latency(input int got, input int exp);
      if (got != exp) begin
         $display("** Error: resp_valid latency = 0x%0h, expected 0x%0h", got, exp);
         errors++;
      end
   endtask

   // called on a falling edge, returns after the accept edge
   task automatic issue(input md_req_t r, output bit ok);
      int t;
      t         = 0;
      req       = r;
      req_valid = 1'b1;
      while (!req_ready && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      ok = req_ready;
      @(posedge clk);
   endtask

   // lat is the index of the current cycle, the accept cycle being cycle 0
   task automatic await_resp(output int lat, output bit ok);
      lat = 1;
      while (!resp_valid && lat < TIMEOUT) begin
         if (req_ready) begin
            $display("test %0d: req_ready went high before the response", ntest);
            errors++;
         end
         @(posedge clk);
         lat++;
         @(negedge clk);
      end
      ok = resp_valid;
   endtask

   // hold keeps req_valid up with nxt while the unit is busy
   task automatic run_one(input md_req_t r, input md_word_t exp, input bit hold,
                          input md_req_t nxt);
      bit ok;
      int lat;
      int nerr;
      ntest++;
      nerr = errors;
      issue(r, ok);
      @(negedge clk);
      req_valid = hold;
      if (hold) begin
         req = nxt;
      end
      if (!ok) begin
         $display("test %0d: request never accepted, req_ready stayed low", ntest);
         errors++;
      end else begin
         await_resp(lat, ok);
         if (!ok) begin
            $display("test %0d: timed out waiting for resp_valid", ntest);
            errors++;
         end else begin
            check_result(resp_result, exp);
            check_latency(lat, (r.op == MD_OP_DIV) ? DIV_LAT : MUL_LAT);
         end
      end
      $display("test %0d: %s %s in_1=%h in_2=%h signed=%b%b %s", ntest, r.op.name(),
               r.out_sel.name(), r.in_1, r.in_2, r.in_1_signed, r.in_2_signed,
               (errors == nerr) ? "ok" : "failed");
   endtask

   initial begin
      md_req_t r;
      void'($urandom(13));
      ntest     = 0;
      errors    = 0;
      reset     = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      repeat (10) @(negedge clk);
      reset = 1'b0;

      for (int i = 0; i < NTBL; i++) begin
         run_one(tbl[i].req, tbl[i].exp, 1'b0, tbl[i].req);
      end

      // second request waits behind a divide
      run_one(tbl[14].req, tbl[14].exp, 1'b1, tbl[6].req);
      run_one(tbl[6].req, tbl[6].exp, 1'b0, tbl[6].req);

      for (int i = 0; i < 40; i++) begin
         r.op          = md_op_e'(1'($urandom));
         r.out_sel     = md_sel_e'(1'($urandom));
         r.in_1_signed = 1'($urandom);
         r.in_2_signed = 1'($urandom);
         r.in_1        = $urandom;
         r.in_2        = $urandom >> (4 * $urandom_range(0, 7));  // spread of divisor sizes
         run_one(r, model_result(r), 1'b0, r);
      end

      $display("tests %0d, errors %0d", ntest, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
